// File: hw/remap_consts.svh
// Width and limit macros for the AXI ID remapper, included by the package and the RTL modules.
`ifndef REMAP_CONSTS_SVH
`define REMAP_CONSTS_SVH

// Slave-side IDs are wide and sparsely used.
`define REMAP_SLV_ID_W 8
// Master-side IDs are narrow and dense.
`define REMAP_MST_ID_W 3

// Each direction tracks this many unique in-flight IDs.
`define REMAP_MAX_IDS 4
// Ceiled binary logarithm of the entry count, which is also the width of the dense ID.
`define REMAP_IDX_W 2

// In-flight transactions allowed per ID, and a counter wide enough to hold that value.
`define REMAP_MAX_TXNS 3
`define REMAP_CNT_W 2

// Payload widths of the reduced AXI channels.
`define REMAP_ADDR_W 16
`define REMAP_DATA_W 32
`define REMAP_LEN_W 8

`endif

// File: hw/remap_pkg.sv
// Shared types of the AXI ID remapper, referenced by scoped name from every RTL module.
`include "remap_consts.svh"

package remap_pkg;

  // IDs on both sides of the remapper.
  typedef logic [`REMAP_SLV_ID_W-1:0] slv_id_t;
  typedef logic [`REMAP_MST_ID_W-1:0] mst_id_t;

  // A table index doubles as the dense output ID before zero extension.
  typedef logic [`REMAP_IDX_W-1:0] idx_t;
  // One bit per table entry.
  typedef logic [`REMAP_MAX_IDS-1:0] field_t;
  typedef logic [`REMAP_CNT_W-1:0] cnt_t;

  // A table entry is free while its counter is zero.
  typedef struct packed {
    slv_id_t slv_id;
    cnt_t    cnt;
  } entry_t;

  // Payload fields that pass through unchanged.
  typedef logic [`REMAP_ADDR_W-1:0] addr_t;
  typedef logic [`REMAP_LEN_W-1:0]  len_t;
  typedef logic [`REMAP_DATA_W-1:0] data_t;
  typedef logic [1:0]               resp_t;

endpackage

// File: hw/id_lzc.sv
// Lowest-set-bit finder over a one-bit-per-entry field, used twice inside the remap table.
`timescale 1ns/1ps
`include "remap_consts.svh"

module id_lzc (
  input  remap_pkg::field_t in_i,
  output remap_pkg::idx_t   idx_o,
  output logic              empty_o
);

  // Scan from the top entry down so that the lowest set bit is the last to win.
  // The result is zero when no bit is set, and empty_o tells the caller to ignore it.
  always_comb begin
    idx_o = '0;
    for (int i = `REMAP_MAX_IDS - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        idx_o = remap_pkg::idx_t'(i);
      end
    end
  end

  // An all-zero field means no free entry or no match, depending on the caller.
  assign empty_o = ~|in_i;

endmodule

// File: hw/id_remap_table.sv
// Remap table of one direction, mapping dense output IDs to slave IDs with in-flight counters.
`timescale 1ns/1ps
`include "remap_consts.svh"

module id_remap_table (
  input  logic                clk_i,
  input  logic                rst_ni,
  output remap_pkg::idx_t     free_idx_o,
  output logic                full_o,
  input  logic                push_i,
  input  remap_pkg::slv_id_t  push_slv_id_i,
  input  remap_pkg::idx_t     push_idx_i,
  input  remap_pkg::slv_id_t  lookup_slv_id_i,
  output logic                exists_o,
  output remap_pkg::idx_t     exists_idx_o,
  output logic                exists_full_o,
  input  logic                pop_i,
  input  remap_pkg::idx_t     pop_idx_i,
  output remap_pkg::slv_id_t  pop_slv_id_o
);

  // The table is indexed by the output ID.
  remap_pkg::entry_t [`REMAP_MAX_IDS-1:0] table_d, table_q;
  remap_pkg::field_t free;
  remap_pkg::field_t match;
  logic              no_match;

  // An entry is free when nothing is in flight on it.
  // It matches the lookup when it is busy and holds the same slave ID.
  always_comb begin
    for (int i = 0; i < `REMAP_MAX_IDS; i++) begin
      free[i]  = table_q[i].cnt == '0;
      match[i] = (table_q[i].cnt != '0) && (table_q[i].slv_id == lookup_slv_id_i);
    end
  end

  // The lowest free entry is the output ID handed to a new slave ID.
  id_lzc u_lzc_free (
    .in_i    (free),
    .idx_o   (free_idx_o),
    .empty_o (full_o)
  );

  // At most one entry can match, so the priority encoder just turns the match into an index.
  id_lzc u_lzc_match (
    .in_i    (match),
    .idx_o   (exists_idx_o),
    .empty_o (no_match)
  );

  assign exists_o      = ~no_match;
  assign exists_full_o = table_q[exists_idx_o].cnt == remap_pkg::cnt_t'(`REMAP_MAX_TXNS);

  // Responses read the slave ID back from the entry of their output ID.
  assign pop_slv_id_o = table_q[pop_idx_i].slv_id;

  // A push and a pop may land in the same cycle, even on the same entry.
  // The pop then cancels the increment and the counter keeps its value.
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[push_idx_i].slv_id = push_slv_id_i;
      table_d[push_idx_i].cnt    = table_d[push_idx_i].cnt + remap_pkg::cnt_t'(1);
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - remap_pkg::cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

  // A busy entry must never be taken over by a different slave ID.
  a_push_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (table_q[push_idx_i].cnt == '0) ||
               (table_q[push_idx_i].slv_id == push_slv_id_i));

  // The channel stalls before the per-ID limit is crossed.
  a_push_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> table_q[push_idx_i].cnt < remap_pkg::cnt_t'(`REMAP_MAX_TXNS));

  // The downstream slave only answers IDs that were issued.
  a_pop_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> table_q[pop_idx_i].cnt != '0);

  // Each slave ID lives in at most one entry.
  a_match_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(match));

endmodule

// File: hw/id_remap_channel.sv
// Request side of one direction, admitting AW or AR requests and choosing their master-side ID.
`timescale 1ns/1ps
`include "remap_consts.svh"

module id_remap_channel (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                slv_valid_i,
  input  remap_pkg::slv_id_t  slv_id_i,
  output logic                slv_ready_o,
  output logic                mst_valid_o,
  output remap_pkg::mst_id_t  mst_id_o,
  input  logic                mst_ready_i,
  input  logic                pop_i,
  input  remap_pkg::idx_t     pop_idx_i,
  output remap_pkg::slv_id_t  pop_slv_id_o
);

  enum logic {st_ready, st_hold} state_d, state_q;

  remap_pkg::idx_t free_idx;
  remap_pkg::idx_t exists_idx;
  remap_pkg::idx_t out_idx;
  remap_pkg::idx_t hold_idx_q;
  logic            full;
  logic            exists;
  logic            exists_full;
  logic            admit;
  logic            push;

  id_remap_table u_table (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .free_idx_o      (free_idx),
    .full_o          (full),
    .push_i          (push),
    .push_slv_id_i   (slv_id_i),
    .push_idx_i      (out_idx),
    .lookup_slv_id_i (slv_id_i),
    .exists_o        (exists),
    .exists_idx_o    (exists_idx),
    .exists_full_o   (exists_full),
    .pop_i           (pop_i),
    .pop_idx_i       (pop_idx_i),
    .pop_slv_id_o    (pop_slv_id_o)
  );

  // A known ID needs room in its own counter, and a new ID needs a free entry.
  assign admit = slv_valid_i && (exists ? !exists_full : !full);

  always_comb begin
    state_d = state_q;
    // Reusing the entry of an in-flight ID keeps the ordering within that ID.
    out_idx     = exists ? exists_idx : free_idx;
    mst_valid_o = 1'b0;
    push        = 1'b0;
    unique case (state_q)
      st_ready: begin
        // The table counts the request as soon as it is forwarded.
        mst_valid_o = admit;
        push        = admit;
        if (admit && !mst_ready_i) begin
          state_d = st_hold;
        end
      end
      st_hold: begin
        // The table already holds this request, so only the stored ID is replayed.
        out_idx     = hold_idx_q;
        mst_valid_o = 1'b1;
        if (mst_ready_i) begin
          state_d = st_ready;
        end
      end
      default: state_d = st_ready;
    endcase
  end

  // The slave side sees ready only when the forwarded request is taken downstream.
  assign slv_ready_o = mst_valid_o && mst_ready_i;

  // Upper bits of the master-side ID are always zero.
  assign mst_id_o = {{(`REMAP_MST_ID_W - `REMAP_IDX_W){1'b0}}, out_idx};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_ready;
    end else begin
      state_q <= state_d;
    end
  end

  // The ID is captured on the push, which is the only cycle that can enter hold.
  always_ff @(posedge clk_i) begin
    if (push) begin
      hold_idx_q <= out_idx;
    end
  end

  // A stalled request keeps its valid and its ID until the master side takes it.
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_valid_o && !mst_ready_i |=> mst_valid_o && $stable(mst_id_o));

endmodule

// File: hw/axi_id_remap.sv
// Top level of the AXI ID remapper, narrowing request IDs and restoring them on responses.
`timescale 1ns/1ps
`include "remap_consts.svh"

module axi_id_remap (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Slave side.
  input  logic                slv_aw_valid_i,
  input  remap_pkg::slv_id_t  slv_aw_id_i,
  input  remap_pkg::addr_t    slv_aw_addr_i,
  input  remap_pkg::len_t     slv_aw_len_i,
  output logic                slv_aw_ready_o,
  input  logic                slv_w_valid_i,
  input  remap_pkg::data_t    slv_w_data_i,
  input  logic                slv_w_last_i,
  output logic                slv_w_ready_o,
  output logic                slv_b_valid_o,
  output remap_pkg::slv_id_t  slv_b_id_o,
  output remap_pkg::resp_t    slv_b_resp_o,
  input  logic                slv_b_ready_i,
  input  logic                slv_ar_valid_i,
  input  remap_pkg::slv_id_t  slv_ar_id_i,
  input  remap_pkg::addr_t    slv_ar_addr_i,
  input  remap_pkg::len_t     slv_ar_len_i,
  output logic                slv_ar_ready_o,
  output logic                slv_r_valid_o,
  output remap_pkg::slv_id_t  slv_r_id_o,
  output remap_pkg::data_t    slv_r_data_o,
  output remap_pkg::resp_t    slv_r_resp_o,
  output logic                slv_r_last_o,
  input  logic                slv_r_ready_i,
  // Master side.
  output logic                mst_aw_valid_o,
  output remap_pkg::mst_id_t  mst_aw_id_o,
  output remap_pkg::addr_t    mst_aw_addr_o,
  output remap_pkg::len_t     mst_aw_len_o,
  input  logic                mst_aw_ready_i,
  output logic                mst_w_valid_o,
  output remap_pkg::data_t    mst_w_data_o,
  output logic                mst_w_last_o,
  input  logic                mst_w_ready_i,
  input  logic                mst_b_valid_i,
  input  remap_pkg::mst_id_t  mst_b_id_i,
  input  remap_pkg::resp_t    mst_b_resp_i,
  output logic                mst_b_ready_o,
  output logic                mst_ar_valid_o,
  output remap_pkg::mst_id_t  mst_ar_id_o,
  output remap_pkg::addr_t    mst_ar_addr_o,
  output remap_pkg::len_t     mst_ar_len_o,
  input  logic                mst_ar_ready_i,
  input  logic                mst_r_valid_i,
  input  remap_pkg::mst_id_t  mst_r_id_i,
  input  remap_pkg::data_t    mst_r_data_i,
  input  remap_pkg::resp_t    mst_r_resp_i,
  input  logic                mst_r_last_i,
  output logic                mst_r_ready_o
);

  logic wr_pop;
  logic rd_pop;

  // Request payloads and the whole W channel carry no ID and pass straight through.
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;
  assign mst_w_valid_o = slv_w_valid_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_last_o  = slv_w_last_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Response handshakes and payloads pass through as well, only the IDs are translated.
  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

  // A write completes with its single B beat.
  // A read completes only with the last R beat of its burst.
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_last_i;

  id_remap_channel u_wr_channel (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_valid_i  (slv_aw_valid_i),
    .slv_id_i     (slv_aw_id_i),
    .slv_ready_o  (slv_aw_ready_o),
    .mst_valid_o  (mst_aw_valid_o),
    .mst_id_o     (mst_aw_id_o),
    .mst_ready_i  (mst_aw_ready_i),
    .pop_i        (wr_pop),
    .pop_idx_i    (mst_b_id_i[`REMAP_IDX_W-1:0]),
    .pop_slv_id_o (slv_b_id_o)
  );

  id_remap_channel u_rd_channel (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_valid_i  (slv_ar_valid_i),
    .slv_id_i     (slv_ar_id_i),
    .slv_ready_o  (slv_ar_ready_o),
    .mst_valid_o  (mst_ar_valid_o),
    .mst_id_o     (mst_ar_id_o),
    .mst_ready_i  (mst_ar_ready_i),
    .pop_i        (rd_pop),
    .pop_idx_i    (mst_r_id_i[`REMAP_IDX_W-1:0]),
    .pop_slv_id_o (slv_r_id_o)
  );

  // A request transferred on the master side is one that the slave side still presents,
  // so it is accepted upstream in the same cycle.
  a_aw_hs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && mst_aw_ready_i |-> slv_aw_valid_i && slv_aw_ready_o);
  a_ar_hs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_ar_valid_o && mst_ar_ready_i |-> slv_ar_valid_i && slv_ar_ready_o);

endmodule

// File: verification/tb_axi_id_remap.sv
// Self-checking testbench of the AXI ID remapper, driving random traffic against a reference model.
`timescale 1ns/1ps
`include "remap_consts.svh"

module tb_axi_id_remap;

  localparam int CLK_PERIOD = 40;
  // Transactions over both directions, split evenly between writes and reads.
  localparam int NUM_TXNS   = 400;
  localparam int DIR_TXNS   = NUM_TXNS / 2;
  localparam int NUM_TESTS  = 6;
  localparam int T_MAP      = 0;
  localparam int T_RESTORE  = 1;
  localparam int T_PASS     = 2;
  localparam int T_STALL    = 3;
  localparam int T_HOLD     = 4;
  localparam int T_RELEASE  = 5;

  // The signals carry the port names so that the DUT connects by name.
  logic clk_i = 1'b0;
  logic rst_ni;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_last_i, slv_w_ready_o;
  logic slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_last_o, mst_w_ready_i;
  logic mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  remap_pkg::slv_id_t slv_aw_id_i, slv_b_id_o, slv_ar_id_i, slv_r_id_o;
  remap_pkg::mst_id_t mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  remap_pkg::addr_t   slv_aw_addr_i, slv_ar_addr_i, mst_aw_addr_o, mst_ar_addr_o;
  remap_pkg::len_t    slv_aw_len_i, slv_ar_len_i, mst_aw_len_o, mst_ar_len_o;
  remap_pkg::data_t   slv_w_data_i, slv_r_data_o, mst_w_data_o, mst_r_data_i;
  remap_pkg::resp_t   slv_b_resp_o, slv_r_resp_o, mst_b_resp_i, mst_r_resp_i;

  // Six slave IDs against four table entries force both reuse and overflow.
  remap_pkg::slv_id_t id_pool [6] = '{8'h03, 8'h5a, 8'h81, 8'hc4, 8'h17, 8'hee};
  string test_name [NUM_TESTS] = '{"id_mapping", "id_restore", "pass_through",
                                   "stall_limits", "hold", "read_release"};
  int test_checks [NUM_TESTS];
  int test_errors [NUM_TESTS];

  // Reference model per direction (0 is write, 1 is read), indexed by the dense ID.
  remap_pkg::slv_id_t model_slv [2][`REMAP_MAX_IDS];
  int                 model_cnt [2][`REMAP_MAX_IDS];
  logic               in_hold [2];
  remap_pkg::idx_t    hold_idx [2];

  // Responder queues per dense ID, answered in order within each queue.
  remap_pkg::slv_id_t wr_q [`REMAP_MAX_IDS][$];
  remap_pkg::slv_id_t rd_q [`REMAP_MAX_IDS][$];
  remap_pkg::len_t    rd_len_q [`REMAP_MAX_IDS][$];

  logic [31:0] rng_state = 32'd63807;
  logic aw_fire, ar_fire, w_fire, b_fire, r_fire;
  int wr_issued, rd_issued, wr_done, rd_done;
  int r_cur;
  int r_beat;
  int total_checks;
  int total_errors;

  axi_id_remap UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Xorshift generator, so the run repeats exactly from the same seed.
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic chance(input int pct);
    return int'(next_rand() % 100) < pct;
  endfunction

  // Starts at a random queue and returns the first one with work, or -1.
  function automatic int pick_queue(input int d);
    int start;
    int q;
    start = int'(next_rand() % `REMAP_MAX_IDS);
    for (int k = 0; k < `REMAP_MAX_IDS; k++) begin
      q = (start + k) % `REMAP_MAX_IDS;
      if ((d == 0 && wr_q[q].size() > 0) || (d == 1 && rd_q[q].size() > 0)) begin
        return q;
      end
    end
    return -1;
  endfunction

  task automatic note_result(input int t, input string what, input logic ok,
                             input logic [31:0] exp, input logic [31:0] act);
    test_checks[t]++;
    if (!ok) begin
      test_errors[t]++;
      $display("Fail %s: %s expected 0x%0h actual 0x%0h", test_name[t], what, exp, act);
    end
  endtask

  task automatic report_error(input int t, input string msg);
    test_checks[t]++;
    test_errors[t]++;
    $display("Error in %s: %s", test_name[t], msg);
  endtask

  task automatic check_slv_id(input int t, input string what,
                              input remap_pkg::slv_id_t exp, input remap_pkg::slv_id_t act);
    note_result(t, what, exp === act, 32'(exp), 32'(act));
  endtask

  task automatic check_mst_id(input int t, input string what,
                              input remap_pkg::mst_id_t exp, input remap_pkg::mst_id_t act);
    note_result(t, what, exp === act, 32'(exp), 32'(act));
  endtask

  task automatic check_data(input int t, input string what,
                            input remap_pkg::data_t exp, input remap_pkg::data_t act);
    note_result(t, what, exp === act, exp, act);
  endtask

  task automatic check_resp(input int t, input string what,
                            input remap_pkg::resp_t exp, input remap_pkg::resp_t act);
    note_result(t, what, exp === act, 32'(exp), 32'(act));
  endtask

  task automatic check_bit(input int t, input string what, input logic exp, input logic act);
    note_result(t, what, exp === act, 32'(exp), 32'(act));
  endtask

  // Predicts admission from the model, checks the chosen ID and records the push.
  task automatic check_request(input int d, input logic slv_valid,
                               input remap_pkg::slv_id_t slv_id, input remap_pkg::len_t len,
                               input logic slv_ready, input logic mst_valid,
                               input remap_pkg::mst_id_t mst_id, input logic mst_ready);
    int hit;
    logic any_free;
    logic admit;
    logic exp_valid;
    remap_pkg::idx_t idx;
    hit = -1;
    any_free = 1'b0;
    for (int i = 0; i < `REMAP_MAX_IDS; i++) begin
      if (model_cnt[d][i] > 0 && model_slv[d][i] == slv_id) begin
        hit = i;
      end
      if (model_cnt[d][i] == 0) begin
        any_free = 1'b1;
      end
    end
    idx = mst_id[`REMAP_IDX_W-1:0];
    if (in_hold[d]) begin
      // The request is already counted, so only its valid and ID are checked.
      exp_valid = 1'b1;
      check_bit(T_HOLD, "held request valid", 1'b1, mst_valid);
      check_mst_id(T_HOLD, "held request ID", remap_pkg::mst_id_t'(hold_idx[d]), mst_id);
    end else begin
      admit = slv_valid && ((hit >= 0) ? (model_cnt[d][hit] < `REMAP_MAX_TXNS) : any_free);
      exp_valid = admit;
      check_bit(T_STALL, "request forwarded", admit, mst_valid);
      if (admit && mst_valid) begin
        check_mst_id(T_MAP, "upper ID bits", '0, remap_pkg::mst_id_t'(mst_id >> `REMAP_IDX_W));
        if (hit >= 0) begin
          check_mst_id(T_MAP, "reused ID", remap_pkg::mst_id_t'(hit), mst_id);
          idx = remap_pkg::idx_t'(hit);
        end else begin
          check_bit(T_MAP, "new ID on a free entry", 1'b1, model_cnt[d][idx] == 0);
        end
        model_slv[d][idx] = slv_id;
        model_cnt[d][idx]++;
        hold_idx[d] = idx;
      end
    end
    // The slave side is accepted exactly when the predicted request meets master-side ready.
    check_bit(T_PASS, "slave-side ready", exp_valid && mst_ready, slv_ready);
    in_hold[d] = exp_valid && !mst_ready;
    // The responder sees the request on the master-side handshake.
    if (mst_valid && mst_ready) begin
      if (d == 0) begin
        wr_q[idx].push_back(slv_id);
      end else begin
        rd_q[idx].push_back(slv_id);
        rd_len_q[idx].push_back(len);
      end
    end
  endtask

  task automatic release_entry(input int d, input remap_pkg::idx_t idx);
    if (model_cnt[d][idx] == 0) begin
      report_error(T_STALL, "a response arrived for an ID with nothing in flight");
    end else begin
      model_cnt[d][idx]--;
    end
  endtask

  task automatic check_pass_through();
    check_data(T_PASS, "AW address", 32'(slv_aw_addr_i), 32'(mst_aw_addr_o));
    check_data(T_PASS, "AW length", 32'(slv_aw_len_i), 32'(mst_aw_len_o));
    check_data(T_PASS, "AR address", 32'(slv_ar_addr_i), 32'(mst_ar_addr_o));
    check_data(T_PASS, "AR length", 32'(slv_ar_len_i), 32'(mst_ar_len_o));
    check_bit(T_PASS, "W valid", slv_w_valid_i, mst_w_valid_o);
    check_data(T_PASS, "W data", slv_w_data_i, mst_w_data_o);
    check_bit(T_PASS, "W last", slv_w_last_i, mst_w_last_o);
    check_bit(T_PASS, "W ready", mst_w_ready_i, slv_w_ready_o);
    check_bit(T_PASS, "B valid", mst_b_valid_i, slv_b_valid_o);
    check_resp(T_PASS, "B resp", mst_b_resp_i, slv_b_resp_o);
    check_bit(T_PASS, "B ready", slv_b_ready_i, mst_b_ready_o);
    check_bit(T_PASS, "R valid", mst_r_valid_i, slv_r_valid_o);
    check_data(T_PASS, "R data", mst_r_data_i, slv_r_data_o);
    check_resp(T_PASS, "R resp", mst_r_resp_i, slv_r_resp_o);
    check_bit(T_PASS, "R last", mst_r_last_i, slv_r_last_o);
    check_bit(T_PASS, "R ready", slv_r_ready_i, mst_r_ready_o);
  endtask

  // Runs mid-cycle, while every input is stable until the next rising edge.
  task automatic sample_and_check();
    remap_pkg::idx_t q;
    check_pass_through();
    check_request(0, slv_aw_valid_i, slv_aw_id_i, slv_aw_len_i, slv_aw_ready_o,
                  mst_aw_valid_o, mst_aw_id_o, mst_aw_ready_i);
    check_request(1, slv_ar_valid_i, slv_ar_id_i, slv_ar_len_i, slv_ar_ready_o,
                  mst_ar_valid_o, mst_ar_id_o, mst_ar_ready_i);
    aw_fire = slv_aw_valid_i && slv_aw_ready_o;
    ar_fire = slv_ar_valid_i && slv_ar_ready_o;
    w_fire  = slv_w_valid_i && slv_w_ready_o;
    b_fire  = mst_b_valid_i && slv_b_ready_i;
    r_fire  = mst_r_valid_i && slv_r_ready_i;
    if (b_fire) begin
      q = mst_b_id_i[`REMAP_IDX_W-1:0];
      check_slv_id(T_RESTORE, "B ID", wr_q[q][0], slv_b_id_o);
      void'(wr_q[q].pop_front());
      release_entry(0, q);
      wr_done++;
    end
    if (r_fire) begin
      q = mst_r_id_i[`REMAP_IDX_W-1:0];
      // Beats after the first show that the entry survived the earlier beats.
      check_slv_id((r_beat == 0) ? T_RESTORE : T_RELEASE, "R ID", rd_q[q][0], slv_r_id_o);
      if (mst_r_last_i) begin
        void'(rd_q[q].pop_front());
        void'(rd_len_q[q].pop_front());
        release_entry(1, q);
        rd_done++;
        r_cur  = -1;
        r_beat = 0;
      end else begin
        r_beat++;
      end
    end
  endtask

  // Runs on the falling edge and keeps every valid and payload stable until its beat transfers.
  task automatic drive_inputs();
    if (aw_fire) slv_aw_valid_i = 1'b0;
    if (ar_fire) slv_ar_valid_i = 1'b0;
    if (w_fire) slv_w_valid_i = 1'b0;
    if (b_fire) mst_b_valid_i = 1'b0;
    if (r_fire) mst_r_valid_i = 1'b0;
    if (!slv_aw_valid_i && wr_issued < DIR_TXNS && chance(50)) begin
      slv_aw_valid_i = 1'b1;
      slv_aw_id_i    = id_pool[int'(next_rand() % 6)];
      slv_aw_addr_i  = remap_pkg::addr_t'(next_rand());
      slv_aw_len_i   = remap_pkg::len_t'(next_rand() % 4);
      wr_issued++;
    end
    if (!slv_ar_valid_i && rd_issued < DIR_TXNS && chance(50)) begin
      slv_ar_valid_i = 1'b1;
      slv_ar_id_i    = id_pool[int'(next_rand() % 6)];
      slv_ar_addr_i  = remap_pkg::addr_t'(next_rand());
      slv_ar_len_i   = remap_pkg::len_t'(next_rand() % 4);
      rd_issued++;
    end
    if (!slv_w_valid_i && chance(40)) begin
      slv_w_valid_i = 1'b1;
      slv_w_data_i  = next_rand();
      slv_w_last_i  = chance(50);
    end
    slv_b_ready_i  = chance(75);
    slv_r_ready_i  = chance(75);
    mst_aw_ready_i = chance(50);
    mst_ar_ready_i = chance(50);
    mst_w_ready_i  = chance(60);
    if (!mst_b_valid_i && chance(60)) begin
      start_b_beat();
    end
    if (!mst_r_valid_i && chance(60)) begin
      if (r_cur < 0) r_cur = pick_queue(1);
      if (r_cur >= 0) begin
        mst_r_valid_i = 1'b1;
        mst_r_id_i    = remap_pkg::mst_id_t'(r_cur);
        mst_r_data_i  = next_rand();
        mst_r_resp_i  = remap_pkg::resp_t'(next_rand());
        mst_r_last_i  = r_beat == int'(rd_len_q[r_cur][0]);
      end
    end
  endtask

  // Starts a B beat for the oldest write of a random busy ID.
  task automatic start_b_beat();
    int q;
    q = pick_queue(0);
    if (q >= 0) begin
      mst_b_valid_i = 1'b1;
      mst_b_id_i    = remap_pkg::mst_id_t'(q);
      mst_b_resp_i  = remap_pkg::resp_t'(next_rand());
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    {slv_aw_valid_i, slv_w_valid_i, slv_w_last_i, slv_b_ready_i, slv_ar_valid_i} = '0;
    {slv_r_ready_i, mst_aw_ready_i, mst_w_ready_i, mst_b_valid_i, mst_ar_ready_i} = '0;
    {mst_r_valid_i, mst_r_last_i} = '0;
    {slv_aw_id_i, slv_ar_id_i, mst_b_id_i, mst_r_id_i} = '0;
    {slv_aw_addr_i, slv_ar_addr_i, slv_aw_len_i, slv_ar_len_i} = '0;
    {slv_w_data_i, mst_r_data_i, mst_b_resp_i, mst_r_resp_i} = '0;
    {aw_fire, ar_fire, w_fire, b_fire, r_fire} = '0;
    in_hold = '{1'b0, 1'b0};
    r_cur  = -1;
    r_beat = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (wr_done < DIR_TXNS || rd_done < DIR_TXNS) begin
      @(negedge clk_i);
      drive_inputs();
      #(CLK_PERIOD / 4);
      sample_and_check();
    end
    // Every request must have come back and freed its entry.
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < `REMAP_MAX_IDS; i++) begin
        if (model_cnt[d][i] != 0) report_error(T_STALL, "an entry is still in flight at the end");
      end
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      $display("%s finished: %0d checks, %0d errors", test_name[t], test_checks[t],
               test_errors[t]);
      total_checks += test_checks[t];
      total_errors += test_errors[t];
    end
    $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Allows 200 cycles per transaction before the run is declared stuck.
  initial begin
    #(NUM_TXNS * 200 * CLK_PERIOD);
    $display("Timeout: the transactions did not complete in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/remap_pkg.sv
hw/id_lzc.sv
hw/id_remap_table.sv
hw/id_remap_channel.sv
hw/axi_id_remap.sv
verification/tb_axi_id_remap.sv

// File: Makefile
# Builds the AXI ID remapper simulation with Verilator and runs it into a log file.
VERILATOR ?= verilator
TOP       ?= tb_axi_id_remap
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source, a header or the file list changes.
$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass message.
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^TEST PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
